//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = rs_tb
FILELIST = vlog.f
LOG      = sim.log
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- design/dispatch_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_alloc
    import rs_pkg::*;
#(
    parameter int rs_entries = 16
) (
    input  logic [rs_entries-1:0]                     entry_valid,
    output logic [dispatch_width-1:0][rs_entries-1:0] alloc_onehot,
    output logic [dispatch_width-1:0]                 struct_stall
);

    // what is still free when lane k runs its search
    logic [dispatch_width-1:0][rs_entries-1:0] search_mask;

    // one-hot of the lowest set bit, zero for an empty mask
    function automatic logic [rs_entries-1:0] lowest_set(input logic [rs_entries-1:0] mask);
        logic [rs_entries-1:0] pick;
        logic                  found;
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < rs_entries; i++) begin
            if (mask[i] && !found) begin
                pick[i] = 1'b1;
                found   = 1'b1;
            end
        end
        return pick;
    endfunction

    // an entry freed by issue shows up here only after the clearing edge
    assign search_mask[0] = ~entry_valid;

    for (genvar k = 0; k < dispatch_width; k++) begin : g_lane
        assign alloc_onehot[k] = lowest_set(search_mask[k]);

        // stall when fewer than k+1 entries are free, independent of dispatch_valid
        assign struct_stall[k] = ~|search_mask[k];

        if (k < dispatch_width - 1) begin : g_chain
            assign search_mask[k+1] = search_mask[k] & ~alloc_onehot[k]; // drop this lane's grant
        end
    end

endmodule

`default_nettype wire

//--- design/issue_select.sv
`timescale 1ns/1ps
`default_nettype none

module issue_select
    import rs_pkg::*;
#(
    parameter int rs_entries = 16
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [rs_entries-1:0]                entry_valid,
    input  logic [rs_entries-1:0]                entry_ready,
    input  logic [rs_entries-1:0][pc_bits-1:0]   entry_pc,
    input  op_t [rs_entries-1:0]                 entry_op,
    input  fu_class_t [rs_entries-1:0]           entry_class,
    input  logic [rs_entries-1:0][tag_bits-1:0]  entry_dest_tag,
    input  logic [rs_entries-1:0][tag_bits-1:0]  entry_src1_tag,
    input  logic [rs_entries-1:0][tag_bits-1:0]  entry_src2_tag,
    input  logic [fu_count-1:0]                  fu_ready,
    output logic [rs_entries-1:0]                issue_clear,
    output logic [issue_width-1:0]               issue_valid,
    output logic [issue_width-1:0][pc_bits-1:0]  issue_pc,
    output op_t [issue_width-1:0]                issue_op,
    output fu_unit_t [issue_width-1:0]           issue_unit,
    output logic [issue_width-1:0][tag_bits-1:0] issue_dest_tag,
    output logic [issue_width-1:0][tag_bits-1:0] issue_src1_tag,
    output logic [issue_width-1:0][tag_bits-1:0] issue_src2_tag
);

    localparam int entry_bits = $clog2(rs_entries);
    localparam int grant_bits = $clog2(issue_width + 1);

    logic [rs_entries-1:0]                  candidate;
    logic [rs_entries-1:0][entry_bits-1:0]  age_rank;   // count of older candidates
    logic [fu_count-1:0]                    unit_free;
    logic [grant_bits-1:0]                  grants;
    logic                                   unit_found;
    fu_unit_t                               unit_pick;
    logic [issue_width-1:0]                 lane_valid;
    logic [issue_width-1:0][pc_bits-1:0]    lane_pc;
    op_t [issue_width-1:0]                  lane_op;
    fu_unit_t [issue_width-1:0]             lane_unit;
    logic [issue_width-1:0][tag_bits-1:0]   lane_dest_tag;
    logic [issue_width-1:0][tag_bits-1:0]   lane_src1_tag;
    logic [issue_width-1:0][tag_bits-1:0]   lane_src2_tag;

    function automatic fu_class_t unit_class(input int u);
        if (u <= int'(unit_alu2))
            return class_alu;
        else if (u <= int'(unit_mult1))
            return class_mult;
        else
            return class_branch;
    endfunction

    assign candidate = entry_valid & entry_ready;

    // lower pc is older, equal pcs fall back to the entry index
    always_comb begin
        for (int i = 0; i < rs_entries; i++) begin
            age_rank[i] = '0;
            for (int j = 0; j < rs_entries; j++) begin
                if (candidate[j] && (entry_pc[j] < entry_pc[i] ||
                                     (entry_pc[j] == entry_pc[i] && j < i)))
                    age_rank[i] = age_rank[i] + 1'b1;
            end
        end
    end

    // walk candidates oldest first, each takes the lowest free unit of its class
    always_comb begin
        unit_free   = fu_ready;
        grants      = '0;
        unit_found  = 1'b0;
        unit_pick   = unit_alu0;
        issue_clear = '0;
        lane_valid  = '0;
        for (int l = 0; l < issue_width; l++) begin
            lane_pc[l]       = '0;
            lane_op[l]       = op_add;
            lane_unit[l]     = unit_alu0;
            lane_dest_tag[l] = '0;
            lane_src1_tag[l] = '0;
            lane_src2_tag[l] = '0;
        end
        for (int r = 0; r < rs_entries; r++) begin
            for (int i = 0; i < rs_entries; i++) begin
                if (candidate[i] && age_rank[i] == entry_bits'(r) &&
                    grants < grant_bits'(issue_width)) begin
                    unit_found = 1'b0;
                    for (int u = fu_count - 1; u >= 0; u--) begin // downward so lowest wins
                        if (unit_free[u] && unit_class(u) == entry_class[i]) begin
                            unit_found = 1'b1;
                            unit_pick  = fu_unit_t'(u);
                        end
                    end
                    if (unit_found) begin
                        unit_free[unit_pick]     = 1'b0;
                        issue_clear[i]           = 1'b1;
                        lane_valid[grants]       = 1'b1;
                        lane_pc[grants]          = entry_pc[i];
                        lane_op[grants]          = entry_op[i];
                        lane_unit[grants]        = unit_pick;
                        lane_dest_tag[grants]    = entry_dest_tag[i];
                        lane_src1_tag[grants]    = entry_src1_tag[i];
                        lane_src2_tag[grants]    = entry_src2_tag[i];
                        grants                   = grants + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset)
            issue_valid <= '0;
        else
            issue_valid <= lane_valid;
    end

    always_ff @(posedge clock) begin
        issue_pc       <= lane_pc;
        issue_op       <= lane_op;
        issue_unit     <= lane_unit;
        issue_dest_tag <= lane_dest_tag;
        issue_src1_tag <= lane_src1_tag;
        issue_src2_tag <= lane_src2_tag;
    end

endmodule

`default_nettype wire

//--- design/rs_entry_table.sv
`timescale 1ns/1ps
`default_nettype none

module rs_entry_table
    import rs_pkg::*;
#(
    parameter int rs_entries = 16
) (
    input  logic                                      clock,
    input  logic                                      reset,
    input  logic [dispatch_width-1:0][rs_entries-1:0] alloc_onehot,
    input  logic [dispatch_width-1:0]                 dispatch_valid,
    input  logic [dispatch_width-1:0][pc_bits-1:0]    dispatch_pc,
    input  op_t [dispatch_width-1:0]                  dispatch_op,
    input  fu_class_t [dispatch_width-1:0]            dispatch_class,
    input  logic [dispatch_width-1:0][tag_bits-1:0]   dispatch_dest_tag,
    input  logic [dispatch_width-1:0][tag_bits-1:0]   dispatch_src1_tag,
    input  logic [dispatch_width-1:0]                 dispatch_src1_ready,
    input  logic [dispatch_width-1:0][tag_bits-1:0]   dispatch_src2_tag,
    input  logic [dispatch_width-1:0]                 dispatch_src2_ready,
    input  logic [cdb_width-1:0]                      cdb_valid,
    input  logic [cdb_width-1:0][tag_bits-1:0]        cdb_tag,
    input  logic [rs_entries-1:0]                     issue_clear,
    output logic [rs_entries-1:0]                     entry_valid,
    output logic [rs_entries-1:0]                     entry_ready,
    output logic [rs_entries-1:0][pc_bits-1:0]        entry_pc,
    output op_t [rs_entries-1:0]                      entry_op,
    output fu_class_t [rs_entries-1:0]                entry_class,
    output logic [rs_entries-1:0][tag_bits-1:0]       entry_dest_tag,
    output logic [rs_entries-1:0][tag_bits-1:0]       entry_src1_tag,
    output logic [rs_entries-1:0][tag_bits-1:0]       entry_src2_tag
);

    localparam int lane_bits = $clog2(dispatch_width);

    logic [rs_entries-1:0]                src1_ready;  // per operand
    logic [rs_entries-1:0]                src2_ready;
    logic [rs_entries-1:0]                valid_next;
    logic [rs_entries-1:0]                src1_next;
    logic [rs_entries-1:0]                src2_next;
    logic [rs_entries-1:0]                write_en;
    logic [rs_entries-1:0][lane_bits-1:0] write_lane;  // which dispatch lane fills the entry

    // any valid broadcast carrying this tag
    function automatic logic tag_hit(
        input logic [tag_bits-1:0]            tag,
        input logic [cdb_width-1:0]           valid,
        input logic [cdb_width-1:0][tag_bits-1:0] bus_tag
    );
        logic hit;
        hit = 1'b0;
        for (int j = 0; j < cdb_width; j++) begin
            hit = hit | (valid[j] && bus_tag[j] == tag);
        end
        return hit;
    endfunction

    // a granted lane only writes if it actually carries an instruction
    always_comb begin
        write_en   = '0;
        write_lane = '0;
        for (int i = 0; i < rs_entries; i++) begin
            for (int k = 0; k < dispatch_width; k++) begin
                if (alloc_onehot[k][i] && dispatch_valid[k]) begin
                    write_en[i]   = 1'b1;
                    write_lane[i] = lane_bits'(k);
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < rs_entries; i++) begin
            valid_next[i] = (entry_valid[i] && !issue_clear[i]) || write_en[i];
            if (write_en[i]) begin
                // same-cycle broadcast counts for a fresh entry
                src1_next[i] = dispatch_src1_ready[write_lane[i]] ||
                               tag_hit(dispatch_src1_tag[write_lane[i]], cdb_valid, cdb_tag);
                src2_next[i] = dispatch_src2_ready[write_lane[i]] ||
                               tag_hit(dispatch_src2_tag[write_lane[i]], cdb_valid, cdb_tag);
            end else begin
                src1_next[i] = src1_ready[i] ||
                               tag_hit(entry_src1_tag[i], cdb_valid, cdb_tag);
                src2_next[i] = src2_ready[i] ||
                               tag_hit(entry_src2_tag[i], cdb_valid, cdb_tag);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
            src1_ready  <= '0;
            src2_ready  <= '0;
            entry_ready <= '0;
        end else begin
            entry_valid <= valid_next;
            src1_ready  <= src1_next;
            src2_ready  <= src2_next;
            entry_ready <= src1_next & src2_next;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_entries; i++) begin
            if (write_en[i]) begin
                entry_pc[i]       <= dispatch_pc[write_lane[i]];
                entry_op[i]       <= dispatch_op[write_lane[i]];
                entry_class[i]    <= dispatch_class[write_lane[i]];
                entry_dest_tag[i] <= dispatch_dest_tag[write_lane[i]];
                entry_src1_tag[i] <= dispatch_src1_tag[write_lane[i]];
                entry_src2_tag[i] <= dispatch_src2_tag[write_lane[i]];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/rs_pkg.sv
`default_nettype none

package rs_pkg;

    // lanes per cycle
    localparam int dispatch_width = 3;
    localparam int cdb_width      = 3;
    localparam int issue_width    = 3;

    localparam int tag_bits = 6;   // physical register tag
    localparam int pc_bits  = 32;

    localparam int fu_count = 6;   // width of fu_ready

    // kind of unit an instruction needs
    typedef enum logic [1:0] {
        class_alu    = 2'd0,
        class_mult   = 2'd1,
        class_branch = 2'd2
    } fu_class_t;

    // concrete units, the value is also the bit position in fu_ready
    typedef enum logic [2:0] {
        unit_alu0    = 3'd0,
        unit_alu1    = 3'd1,
        unit_alu2    = 3'd2,
        unit_mult0   = 3'd3,
        unit_mult1   = 3'd4,
        unit_branch0 = 3'd5
    } fu_unit_t;

    // carried through the station untouched
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_mul = 3'd4,
        op_beq = 3'd5,
        op_bne = 3'd6
    } op_t;

endpackage

`default_nettype wire

//--- design/rs_top.sv
`timescale 1ns/1ps
`default_nettype none

module rs_top
    import rs_pkg::*;
#(
    parameter int rs_entries = 16
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic [dispatch_width-1:0]               dispatch_valid,
    input  logic [dispatch_width-1:0][pc_bits-1:0]  dispatch_pc,
    input  op_t [dispatch_width-1:0]                dispatch_op,
    input  fu_class_t [dispatch_width-1:0]          dispatch_class,
    input  logic [dispatch_width-1:0][tag_bits-1:0] dispatch_dest_tag,
    input  logic [dispatch_width-1:0][tag_bits-1:0] dispatch_src1_tag,
    input  logic [dispatch_width-1:0]               dispatch_src1_ready,
    input  logic [dispatch_width-1:0][tag_bits-1:0] dispatch_src2_tag,
    input  logic [dispatch_width-1:0]               dispatch_src2_ready,
    input  logic [cdb_width-1:0]                    cdb_valid,
    input  logic [cdb_width-1:0][tag_bits-1:0]      cdb_tag,
    input  logic [fu_count-1:0]                     fu_ready,
    output logic [dispatch_width-1:0]               struct_stall,
    output logic [issue_width-1:0]                  issue_valid,
    output logic [issue_width-1:0][pc_bits-1:0]     issue_pc,
    output op_t [issue_width-1:0]                   issue_op,
    output fu_unit_t [issue_width-1:0]              issue_unit,
    output logic [issue_width-1:0][tag_bits-1:0]    issue_dest_tag,
    output logic [issue_width-1:0][tag_bits-1:0]    issue_src1_tag,
    output logic [issue_width-1:0][tag_bits-1:0]    issue_src2_tag
);

    logic [dispatch_width-1:0][rs_entries-1:0] alloc_onehot;
    logic [rs_entries-1:0]                     issue_clear;
    logic [rs_entries-1:0]                     entry_valid;
    logic [rs_entries-1:0]                     entry_ready;
    logic [rs_entries-1:0][pc_bits-1:0]        entry_pc;
    op_t [rs_entries-1:0]                      entry_op;
    fu_class_t [rs_entries-1:0]                entry_class;
    logic [rs_entries-1:0][tag_bits-1:0]       entry_dest_tag;
    logic [rs_entries-1:0][tag_bits-1:0]       entry_src1_tag;
    logic [rs_entries-1:0][tag_bits-1:0]       entry_src2_tag;

    dispatch_alloc #(
        .rs_entries (rs_entries)
    ) u_alloc (
        .entry_valid  (entry_valid),
        .alloc_onehot (alloc_onehot),
        .struct_stall (struct_stall)
    );

    rs_entry_table #(
        .rs_entries (rs_entries)
    ) u_table (
        .clock               (clock),
        .reset               (reset),
        .alloc_onehot        (alloc_onehot),
        .dispatch_valid      (dispatch_valid),
        .dispatch_pc         (dispatch_pc),
        .dispatch_op         (dispatch_op),
        .dispatch_class      (dispatch_class),
        .dispatch_dest_tag   (dispatch_dest_tag),
        .dispatch_src1_tag   (dispatch_src1_tag),
        .dispatch_src1_ready (dispatch_src1_ready),
        .dispatch_src2_tag   (dispatch_src2_tag),
        .dispatch_src2_ready (dispatch_src2_ready),
        .cdb_valid           (cdb_valid),
        .cdb_tag             (cdb_tag),
        .issue_clear         (issue_clear),
        .entry_valid         (entry_valid),
        .entry_ready         (entry_ready),
        .entry_pc            (entry_pc),
        .entry_op            (entry_op),
        .entry_class         (entry_class),
        .entry_dest_tag      (entry_dest_tag),
        .entry_src1_tag      (entry_src1_tag),
        .entry_src2_tag      (entry_src2_tag)
    );

    issue_select #(
        .rs_entries (rs_entries)
    ) u_issue (
        .clock          (clock),
        .reset          (reset),
        .entry_valid    (entry_valid),
        .entry_ready    (entry_ready),
        .entry_pc       (entry_pc),
        .entry_op       (entry_op),
        .entry_class    (entry_class),
        .entry_dest_tag (entry_dest_tag),
        .entry_src1_tag (entry_src1_tag),
        .entry_src2_tag (entry_src2_tag),
        .fu_ready       (fu_ready),
        .issue_clear    (issue_clear),
        .issue_valid    (issue_valid),
        .issue_pc       (issue_pc),
        .issue_op       (issue_op),
        .issue_unit     (issue_unit),
        .issue_dest_tag (issue_dest_tag),
        .issue_src1_tag (issue_src1_tag),
        .issue_src2_tag (issue_src2_tag)
    );

endmodule

`default_nettype wire

//--- tests/rs_model.svh
`ifndef RS_MODEL_SVH
`define RS_MODEL_SVH

// reference pool, slot i stands for entry i of the station
logic [15:0]      m_valid, m_rdy1, m_rdy2;
logic [31:0]      m_pc [16];
op_t              m_op [16];
fu_class_t        m_class [16];
logic [5:0]       m_dest [16], m_src1 [16], m_src2 [16];

// issue lanes and stalls expected right after the coming edge
logic [2:0]       exp_valid, exp_stall;
logic [2:0][31:0] exp_pc;
op_t [2:0]        exp_op;
fu_unit_t [2:0]   exp_unit;
logic [2:0][5:0]  exp_dest, exp_src1, exp_src2;
int               accepted_n;

function automatic logic on_cdb(input logic [5:0] tag);
    for (int j = 0; j < 3; j++)
        if (cdb_valid[j] && cdb_tag[j] == tag)
            return 1'b1;
    return 1'b0;
endfunction

function automatic int pool_count();
    return $countones(m_valid);
endfunction

// oldest ready entry first, each one takes the first free unit of its class
function automatic logic [15:0] predict_issue(input logic [5:0] units);
    logic [15:0] seen;
    logic [15:0] clear;
    int          best, lanes, lo, hi, pick;
    seen      = '0;
    clear     = '0;
    lanes     = 0;
    exp_valid = '0;
    for (int n = 0; n < 16; n++) begin
        best = -1;
        for (int i = 0; i < 16; i++)
            if (m_valid[i] && m_rdy1[i] && m_rdy2[i] && !seen[i] &&
                (best < 0 || m_pc[i] < m_pc[best]))
                best = i;
        if (best >= 0 && lanes < 3) begin
            seen[best] = 1'b1;
            lo = m_class[best] == class_alu ? 0 : (m_class[best] == class_mult ? 3 : 5);
            hi = m_class[best] == class_alu ? 2 : (m_class[best] == class_mult ? 4 : 5);
            pick = -1;
            for (int u = hi; u >= lo; u--)
                if (units[u])
                    pick = u;
            if (pick >= 0) begin  // no unit left means the entry just waits
                units[pick]      = 1'b0;
                clear[best]      = 1'b1;
                exp_valid[lanes] = 1'b1;
                exp_pc[lanes]    = m_pc[best];
                exp_op[lanes]    = m_op[best];
                exp_unit[lanes]  = fu_unit_t'(pick);
                exp_dest[lanes]  = m_dest[best];
                exp_src1[lanes]  = m_src1[best];
                exp_src2[lanes]  = m_src2[best];
                lanes++;
            end
        end
    end
    return clear;
endfunction

// advance the pool across one edge with the inputs now driven
task automatic model_cycle();
    logic [15:0] clear;
    int          k;
    k     = 0;
    clear = predict_issue(fu_ready);
    for (int i = 0; i < 16; i++) begin
        if (m_valid[i]) begin
            m_rdy1[i] = m_rdy1[i] | on_cdb(m_src1[i]);
            m_rdy2[i] = m_rdy2[i] | on_cdb(m_src2[i]);
        end else begin
            // lane k owns the k-th free slot whether it dispatches or not
            if (k < 3 && dispatch_valid[k]) begin
                m_valid[i] = 1'b1;
                m_pc[i]    = dispatch_pc[k];
                m_op[i]    = dispatch_op[k];
                m_class[i] = dispatch_class[k];
                m_dest[i]  = dispatch_dest_tag[k];
                m_src1[i]  = dispatch_src1_tag[k];
                m_src2[i]  = dispatch_src2_tag[k];
                m_rdy1[i]  = dispatch_src1_ready[k] | on_cdb(dispatch_src1_tag[k]);
                m_rdy2[i]  = dispatch_src2_ready[k] | on_cdb(dispatch_src2_tag[k]);
                accepted_n++;
            end
            k++;
        end
    end
    m_valid = m_valid & ~clear;
    for (int s = 0; s < 3; s++)
        exp_stall[s] = (16 - pool_count()) <= s;
endtask

`endif

//--- tests/rs_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rs_tb
    import rs_pkg::*;
();

    // cycle budget of each test, the watchdog allows their sum
    localparam int budget_reset    = 12;
    localparam int budget_latency  = 40;
    localparam int budget_wakeup   = 50;
    localparam int budget_order    = 45;
    localparam int budget_pressure = 200;
    localparam int budget_stall    = 65;
    localparam int budget_random   = 2070;
    localparam int budget_cycles   = budget_reset + budget_latency + budget_wakeup +
                                     budget_order + budget_pressure + budget_stall + budget_random;

    logic             clock;
    logic             reset;
    logic [2:0]       dispatch_valid, dispatch_src1_ready, dispatch_src2_ready;
    logic [2:0][31:0] dispatch_pc;
    op_t [2:0]        dispatch_op;
    fu_class_t [2:0]  dispatch_class;
    logic [2:0][5:0]  dispatch_dest_tag, dispatch_src1_tag, dispatch_src2_tag;
    logic [2:0]       cdb_valid;
    logic [2:0][5:0]  cdb_tag;
    logic [5:0]       fu_ready;
    logic [2:0]       struct_stall, issue_valid;
    logic [2:0][31:0] issue_pc;
    op_t [2:0]        issue_op;
    fu_unit_t [2:0]   issue_unit;
    logic [2:0][5:0]  issue_dest_tag, issue_src1_tag, issue_src2_tag;

    logic [31:0] rng_state;
    logic [5:0]  checked_fu;  // fu_ready of the cycle under check
    logic        check_armed;
    int          error_count, tests_pass, tests_fail, issued_n;

    `include "rs_model.svh"

    rs_top #(.rs_entries(16)) dut0 (.*);

    initial clock = 1'b0;
    always #10 clock = ~clock;

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic report_mismatch(input string name, input int lane,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("ERROR %s[%0d] expected %h actual %h at %0t", name, lane, expected, actual, $time);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("%s at %0t", what, $time);
        error_count++;
    endtask

    task automatic clear_inputs();
        dispatch_valid      = '0;
        dispatch_pc         = '0;
        dispatch_dest_tag   = '0;
        dispatch_src1_tag   = '0;
        dispatch_src2_tag   = '0;
        dispatch_src1_ready = '0;
        dispatch_src2_ready = '0;
        cdb_valid           = '0;
        cdb_tag             = '0;
        for (int k = 0; k < 3; k++) begin
            dispatch_op[k]    = op_add;
            dispatch_class[k] = class_alu;
        end
    endtask

    // random pc, op and dest on lane k
    task automatic put_lane(input int k, input fu_class_t cls, input logic [5:0] src1,
                            input logic rdy1, input logic [5:0] src2, input logic rdy2);
        logic [31:0] r;
        logic [31:0] d;
        r = xorshift();
        d = xorshift();
        dispatch_valid[k]      = 1'b1;
        dispatch_pc[k]         = {r[31:2], 2'b00};
        dispatch_class[k]      = cls;
        dispatch_op[k]         = cls == class_mult ? op_mul :
                                 cls == class_branch ? (r[0] ? op_bne : op_beq) :
                                 op_t'({1'b0, r[1:0]});
        dispatch_dest_tag[k]   = d[5:0];
        dispatch_src1_tag[k]   = src1;
        dispatch_src1_ready[k] = rdy1;
        dispatch_src2_tag[k]   = src2;
        dispatch_src2_ready[k] = rdy2;
    endtask

    task automatic step();
        model_cycle();
        checked_fu  = fu_ready;
        check_armed = 1'b1;
        @(negedge clock);
    endtask

    // wake every tag and free all units until the pool is empty
    task automatic drain(input int max_cycles);
        int n;
        n = 0;
        while (pool_count() > 0 && n < max_cycles) begin
            clear_inputs();
            cdb_valid = 3'b111;
            for (int j = 0; j < 3; j++)
                cdb_tag[j] = 6'((3 * n + j) % 64);
            fu_ready = '1;
            step();
            n++;
        end
        if (pool_count() > 0)
            report_failure("pool did not drain in time");
        clear_inputs();
    endtask

    task automatic finish_test(input string name, input int start);
        if (error_count == start) begin
            tests_pass++;
            $display("test %s passed", name);
        end else begin
            tests_fail++;
            $display("test %s failed with %0d errors", name, error_count - start);
        end
    endtask

    // outputs compared one step after each rising edge
    always @(posedge clock) begin
        #1;
        if (check_armed) begin
            if (issue_valid !== exp_valid)
                report_mismatch("issue_valid", 0, 32'(exp_valid), 32'(issue_valid));
            if (struct_stall !== exp_stall)
                report_mismatch("struct_stall", 0, 32'(exp_stall), 32'(struct_stall));
            for (int l = 0; l < 3; l++) begin
                if (issue_valid[l]) begin
                    issued_n++;
                    if (!checked_fu[issue_unit[l]])
                        report_failure("issue to a unit whose ready flag was low");
                    for (int m = 0; m < l; m++)
                        if (issue_valid[m] && issue_unit[m] == issue_unit[l])
                            report_failure("two issue lanes granted the same unit");
                end
                if (exp_valid[l] && issue_valid[l]) begin
                    if (issue_pc[l] !== exp_pc[l])
                        report_mismatch("issue_pc", l, exp_pc[l], issue_pc[l]);
                    if (issue_op[l] !== exp_op[l])
                        report_mismatch("issue_op", l, 32'(exp_op[l]), 32'(issue_op[l]));
                    if (issue_unit[l] !== exp_unit[l])
                        report_mismatch("issue_unit", l, 32'(exp_unit[l]), 32'(issue_unit[l]));
                    if (issue_dest_tag[l] !== exp_dest[l])
                        report_mismatch("issue_dest_tag", l, 32'(exp_dest[l]),
                                        32'(issue_dest_tag[l]));
                    if (issue_src1_tag[l] !== exp_src1[l])
                        report_mismatch("issue_src1_tag", l, 32'(exp_src1[l]),
                                        32'(issue_src1_tag[l]));
                    if (issue_src2_tag[l] !== exp_src2[l])
                        report_mismatch("issue_src2_tag", l, 32'(exp_src2[l]),
                                        32'(issue_src2_tag[l]));
                end
            end
        end
    end

    task automatic test_reset_latency();
        int start;
        start = error_count;
        if (issue_valid !== 3'b000)
            report_mismatch("issue_valid", 0, 32'h0, 32'(issue_valid));
        if (struct_stall !== 3'b000)
            report_mismatch("struct_stall", 0, 32'h0, 32'(struct_stall));
        fu_ready = 6'b110111;  // mult0 busy
        put_lane(0, class_alu, 6'd1, 1'b1, 6'd2, 1'b1);
        put_lane(1, class_mult, 6'd3, 1'b1, 6'd4, 1'b1);
        step();
        clear_inputs();
        step();
        if (issue_valid[1:0] !== 2'b11)
            report_mismatch("issue_valid", 0, 32'h3, 32'(issue_valid[1:0]));
        drain(30);
        finish_test("reset_latency", start);
    endtask

    task automatic test_wakeup();
        int start;
        start = error_count;
        fu_ready = '1;
        put_lane(0, class_alu, 6'd10, 1'b0, 6'd3, 1'b1);
        put_lane(1, class_mult, 6'd11, 1'b1, 6'd12, 1'b0);
        put_lane(2, class_branch, 6'd13, 1'b0, 6'd13, 1'b0);
        step();
        clear_inputs();
        repeat (4) step();
        if (issue_valid !== 3'b000)
            report_mismatch("issue_valid", 0, 32'h0, 32'(issue_valid));
        // dispatch and broadcast of tag 20 in one cycle
        put_lane(0, class_alu, 6'd20, 1'b0, 6'd20, 1'b0);
        cdb_valid  = 3'b011;
        cdb_tag[0] = 6'd20;
        cdb_tag[1] = 6'd10;
        step();
        clear_inputs();
        cdb_valid = 3'b111;
        cdb_tag   = {6'd13, 6'd12, 6'd11};
        step();
        clear_inputs();
        repeat (4) step();
        drain(30);
        finish_test("wakeup", start);
    endtask

    task automatic test_oldest_first();
        int start;
        start = error_count;
        fu_ready = '0;  // hold everything until the pool holds nine
        for (int c = 0; c < 3; c++) begin
            for (int k = 0; k < 3; k++)
                put_lane(k, class_alu, 6'd0, 1'b1, 6'd0, 1'b1);
            step();
        end
        clear_inputs();
        fu_ready = '1;
        repeat (5) step();
        drain(30);
        finish_test("oldest_first", start);
    endtask

    task automatic test_unit_pressure();
        int          start;
        logic [31:0] r;
        start = error_count;
        for (int c = 0; c < 150; c++) begin
            clear_inputs();
            r = xorshift();
            for (int k = 0; k < 3; k++)
                if (r[k])
                    put_lane(k, fu_class_t'(2'(r[15:8] % 3)), r[21:16], 1'b1, r[27:22], 1'b1);
            fu_ready = r[31:26];
            step();
        end
        drain(40);
        finish_test("unit_pressure", start);
    endtask

    task automatic test_struct_stall();
        int start;
        int tries;
        start = error_count;
        tries = 0;
        fu_ready = '1;
        while (pool_count() < 16 && tries < 10) begin
            clear_inputs();
            for (int k = 0; k < 3; k++)
                put_lane(k, class_alu, 6'(32 + (tries * 3 + k) % 16), 1'b0, 6'd0, 1'b1);
            step();
            tries++;
        end
        if (struct_stall !== 3'b111)
            report_mismatch("struct_stall", 0, 32'h7, 32'(struct_stall));
        for (int t = 0; t < 16; t++) begin
            clear_inputs();
            cdb_valid[0] = 1'b1;
            cdb_tag[0]   = 6'(32 + t);
            put_lane(0, class_alu, 6'd0, 1'b1, 6'd0, 1'b1);
            put_lane(1, class_alu, 6'd0, 1'b1, 6'd0, 1'b1);
            step();
        end
        drain(30);
        finish_test("struct_stall", start);
    endtask

    task automatic test_random_mix();
        int          start;
        logic [31:0] r;
        logic [31:0] t;
        start = error_count;
        for (int c = 0; c < 2000; c++) begin
            clear_inputs();
            r = xorshift();
            for (int k = 0; k < 3; k++) begin
                t = xorshift();
                if (r[k] | r[k + 3])
                    put_lane(k, fu_class_t'(2'(t % 3)), t[7:2], t[8] | t[16], t[14:9],
                             t[15] | t[17]);
            end
            t = xorshift();
            cdb_valid = r[8:6];
            cdb_tag   = t[17:0];
            fu_ready  = r[14:9] | r[20:15];
            step();
        end
        drain(60);
        if (issued_n != accepted_n)
            report_mismatch("issued_count", 0, 32'(accepted_n), 32'(issued_n));
        finish_test("random_mix", start);
    endtask

    initial begin
        rng_state   = 32'd90;
        error_count = 0;
        tests_pass  = 0;
        tests_fail  = 0;
        issued_n    = 0;
        accepted_n  = 0;
        check_armed = 1'b0;
        checked_fu  = '0;
        m_valid     = '0;
        m_rdy1      = '0;
        m_rdy2      = '0;
        reset       = 1'b1;
        fu_ready    = '0;
        clear_inputs();
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        test_reset_latency();
        test_wakeup();
        test_oldest_first();
        test_unit_pressure();
        test_struct_stall();
        test_random_mix();
        $display("summary: %0d tests passed, %0d failed, %0d errors",
                 tests_pass, tests_fail, error_count);
        if (tests_fail == 0 && error_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        #(budget_cycles * 20 + 1000);
        $display("watchdog expired, the tests did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+tests
design/rs_pkg.sv
design/dispatch_alloc.sv
design/rs_entry_table.sv
design/issue_select.sv
design/rs_top.sv
tests/rs_tb.sv
